//--- include/burst_config.svh
`ifndef BURST_CONFIG_SVH
`define BURST_CONFIG_SVH

// number of burst pumps running in parallel
`define BURST_LANES 4

// address bus width in bits
`define BURST_ADDR_W 32

// data bus width in bits, one strobe bit per byte
`define BURST_DATA_W 64

// strobe width derived from the data bus
`define BURST_STRB_W (`BURST_DATA_W / 8)

// transaction id width
`define BURST_ID_W 4

`endif

//--- src/burst_pkg.sv
`default_nettype none

`include "burst_config.svh"

package burst_pkg;

  // axi burst type, encoding follows AxBURST
  // 2'b11 is reserved and never generated by the stimulus
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  // pump FSM
  // idle waits for a descriptor, send walks its beats
  typedef enum logic {
    IDLE = 1'b0,
    SEND = 1'b1
  } pump_state_e;

  // burst descriptor as seen on the address channel
  typedef struct packed {
    // transaction id, passed through to every beat
    logic [`BURST_ID_W-1:0]   id;
    // start address, may be unaligned for fixed and incr
    logic [`BURST_ADDR_W-1:0] addr;
    burst_e                   burst;
    // number of beats minus one
    logic [7:0]               len;
    // log2 of bytes per beat
    logic [2:0]               size;
  } burst_req_t;

  // one generated transfer
  typedef struct packed {
    logic [`BURST_ID_W-1:0]   id;
    // address of this transfer
    logic [`BURST_ADDR_W-1:0] addr;
    // active byte lanes on the data bus
    logic [`BURST_STRB_W-1:0] strb;
    // set on beat 0
    logic                     first;
    // set on beat len
    logic                     last;
  } beat_t;

endpackage

`default_nettype wire

//--- src/burst_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

`include "burst_config.svh"

module burst_dispatch (
  input  wire                                           aclk,
  input  wire                                           reset,
  // descriptor from the top level
  input  wire                                           req_valid_i,
  input  wire burst_pkg::burst_req_t                    req_i,
  output logic                                          req_ready_o,
  // one link per pump
  output logic [`BURST_LANES-1:0]                       lane_valid_o,
  output burst_pkg::burst_req_t [`BURST_LANES-1:0]      lane_req_o,
  input  wire [`BURST_LANES-1:0]                        lane_ready_i
);

  localparam int LANES = `BURST_LANES;
  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  logic [PTR_W-1:0] ptr_r;
  logic [PTR_W-1:0] sel;
  logic             found;

  // first ready lane starting at the pointer
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    sel   = '0;
    for (int i = 0; i < LANES; i++) begin
      idx = (int'(ptr_r) + i) % LANES;
      if (!found && lane_ready_i[idx]) begin
        found = 1'b1;
        sel   = PTR_W'(idx);
      end
    end
  end

  assign req_ready_o = found;

  // valid goes to the chosen lane only, payload to every lane
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_valid_o[i] = req_valid_i & found & (sel == PTR_W'(i));
      lane_req_o[i]   = req_i;
    end
  end

  // pointer steps past the lane that took the descriptor
  always_ff @(posedge aclk) begin
    if (reset) begin
      ptr_r <= '0;
    end else if (req_valid_i && found) begin
      if (sel == PTR_W'(LANES - 1)) begin
        ptr_r <= '0;
      end else begin
        ptr_r <= sel + PTR_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- src/burst_pump.sv
`timescale 1ns/10ps
`default_nettype none

`include "burst_config.svh"

module burst_pump (
  input  wire                        aclk,
  input  wire                        reset,
  // descriptor in from the dispatcher
  input  wire                        req_valid_i,
  input  wire burst_pkg::burst_req_t req_i,
  output logic                       req_ready_o,
  // beats out to the arbiter
  output logic                       beat_valid_o,
  output burst_pkg::beat_t           beat_o,
  input  wire                        beat_ready_i
);

  import burst_pkg::*;

  localparam int ADDR_W    = `BURST_ADDR_W;
  localparam int STRB_W    = `BURST_STRB_W;
  localparam int LG_STRB_W = $clog2(STRB_W);

  // highest byte lane index on the bus
  localparam logic [LG_STRB_W-1:0] TOP_LANE = LG_STRB_W'(STRB_W - 1);

  pump_state_e state_r;
  burst_req_t  req_r;
  logic [7:0]  count_r;
  logic [ADDR_W-1:0] addr_r;
  logic [ADDR_W-1:0] addr_next;

  logic accept;
  logic send;
  logic send_last;

  // address arithmetic
  logic [ADDR_W-1:0] num_bytes;
  logic [ADDR_W-1:0] aligned_addr;
  logic [ADDR_W-1:0] aligned_incr;
  logic [ADDR_W-1:0] last_byte;
  logic [2:0]        lg_len;
  logic [3:0]        wrap_shift;
  logic [ADDR_W-1:0] wrap_lower;
  logic [ADDR_W-1:0] wrap_upper;
  logic              do_wrap;

  // strobe construction
  logic [LG_STRB_W-1:0] lower_lane;
  logic [LG_STRB_W-1:0] upper_lane;
  logic [STRB_W-1:0]    mask_lo;
  logic [STRB_W-1:0]    mask_hi;

  // one burst at a time, ready only while idle
  assign req_ready_o  = (state_r == IDLE);
  assign beat_valid_o = (state_r == SEND);

  assign accept    = req_valid_i & req_ready_o;
  assign send      = beat_valid_o & beat_ready_i;
  assign send_last = send & (count_r == req_r.len);

  // state machine
  always_ff @(posedge aclk) begin
    if (reset) begin
      state_r <= IDLE;
    end else begin
      case (state_r)
        IDLE: begin
          if (accept) begin
            state_r <= SEND;
          end
        end
        SEND: begin
          // back to idle once the final beat leaves
          if (send_last) begin
            state_r <= IDLE;
          end
        end
        default: begin
          state_r <= IDLE;
        end
      endcase
    end
  end

  // beat counter, restarts from zero on every new descriptor
  always_ff @(posedge aclk) begin
    if (reset) begin
      count_r <= '0;
    end else if (accept) begin
      count_r <= '0;
    end else if (send) begin
      count_r <= count_r + 8'd1;
    end
  end

  // descriptor and running address
  always_ff @(posedge aclk) begin
    if (accept) begin
      req_r  <= req_i;
      addr_r <= req_i.addr;
    end else if (send) begin
      addr_r <= addr_next;
    end
  end

  // bytes per beat and the aligned form of the current address
  assign num_bytes    = ADDR_W'(1) << req_r.size;
  assign aligned_addr = (addr_r >> req_r.size) << req_r.size;
  assign aligned_incr = aligned_addr + num_bytes;

  // wrap lengths are limited to 2, 4, 8 or 16
  // so a small table replaces a general log2
  always_comb begin
    case (req_r.len)
      8'd1:    lg_len = 3'd1;
      8'd3:    lg_len = 3'd2;
      8'd7:    lg_len = 3'd3;
      8'd15:   lg_len = 3'd4;
      default: lg_len = 3'd0;
    endcase
  end

  // wrap region is beats * bytes, i.e. 1 << (lg_len + size)
  assign wrap_shift = {1'b0, lg_len} + {1'b0, req_r.size};
  assign wrap_lower = (req_r.addr >> wrap_shift) << wrap_shift;
  assign wrap_upper = wrap_lower + (ADDR_W'(1) << wrap_shift);
  // exact match also holds for a region at the very top of the address space
  assign do_wrap    = (aligned_incr == wrap_upper);

  // next beat address by burst type
  always_comb begin
    case (req_r.burst)
      // fixed keeps the start address on every beat
      FIXED: addr_next = addr_r;
      INCR:  addr_next = aligned_incr;
      // start is aligned, so only the region end needs care
      WRAP:  addr_next = do_wrap ? wrap_lower : aligned_incr;
      default: addr_next = addr_r;
    endcase
  end

  // byte lanes run from the current address up to the end of its aligned chunk
  assign last_byte  = aligned_incr - ADDR_W'(1);
  assign lower_lane = addr_r[LG_STRB_W-1:0];
  assign upper_lane = last_byte[LG_STRB_W-1:0];

  // ones at and above the lower lane
  assign mask_lo = {STRB_W{1'b1}} << lower_lane;
  // ones at and below the upper lane
  assign mask_hi = {STRB_W{1'b1}} >> (TOP_LANE - upper_lane);

  // outgoing beat
  always_comb begin
    beat_o.id    = req_r.id;
    beat_o.addr  = addr_r;
    beat_o.strb  = mask_lo & mask_hi;
    beat_o.first = (count_r == 8'd0);
    beat_o.last  = (count_r == req_r.len);
  end

endmodule

`default_nettype wire

//--- src/beat_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "burst_config.svh"

module beat_arbiter (
  input  wire                                      aclk,
  input  wire                                      reset,
  // beats offered by the pumps
  input  wire [`BURST_LANES-1:0]                   pump_valid_i,
  input  wire burst_pkg::beat_t [`BURST_LANES-1:0] pump_beat_i,
  output logic [`BURST_LANES-1:0]                  pump_ready_o,
  // registered output
  output logic                                     beat_valid_o,
  output burst_pkg::beat_t                         beat_o,
  input  wire                                      beat_ready_i
);

  import burst_pkg::*;

  localparam int LANES = `BURST_LANES;
  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  logic [PTR_W-1:0] ptr_r;
  logic [PTR_W-1:0] sel;
  logic [LANES-1:0] gnt;
  logic             found;
  logic             load_en;

  logic  out_valid_r;
  beat_t out_beat_r;

  // slot can take a new beat when empty or draining this cycle
  assign load_en = ~out_valid_r | beat_ready_i;

  // round-robin search, one-hot grant
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    sel   = '0;
    gnt   = '0;
    for (int i = 0; i < LANES; i++) begin
      idx = (int'(ptr_r) + i) % LANES;
      if (!found && pump_valid_i[idx]) begin
        found    = 1'b1;
        sel      = PTR_W'(idx);
        gnt[idx] = 1'b1;
      end
    end
  end

  // only the winner sees ready, and only when the slot loads
  assign pump_ready_o = load_en ? gnt : '0;

  // output valid and pointer
  always_ff @(posedge aclk) begin
    if (reset) begin
      out_valid_r <= 1'b0;
      ptr_r       <= '0;
    end else if (load_en) begin
      out_valid_r <= found;
      if (found) begin
        ptr_r <= (sel == PTR_W'(LANES - 1)) ? '0 : sel + PTR_W'(1);
      end
    end
  end

  // beat payload
  always_ff @(posedge aclk) begin
    if (load_en && found) begin
      out_beat_r <= pump_beat_i[sel];
    end
  end

  assign beat_valid_o = out_valid_r;
  assign beat_o       = out_beat_r;

endmodule

`default_nettype wire

//--- src/burst_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "burst_config.svh"

module burst_addr_gen (
  input  wire                        aclk,
  input  wire                        reset,
  // burst descriptors
  input  wire                        req_valid_i,
  input  wire burst_pkg::burst_req_t req_i,
  output logic                       req_ready_o,
  // interleaved beats
  output logic                       beat_valid_o,
  output burst_pkg::beat_t           beat_o,
  input  wire                        beat_ready_i
);

  import burst_pkg::*;

  localparam int LANES = `BURST_LANES;

  // dispatcher to pumps
  wire [LANES-1:0]             lane_valid;
  wire burst_req_t [LANES-1:0] lane_req;
  wire [LANES-1:0]             lane_ready;

  // pumps to arbiter
  wire [LANES-1:0]        pump_valid;
  wire beat_t [LANES-1:0] pump_beat;
  wire [LANES-1:0]        pump_ready;

  burst_dispatch burst_dispatch_inst (
    .aclk         (aclk),
    .reset        (reset),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .lane_valid_o (lane_valid),
    .lane_req_o   (lane_req),
    .lane_ready_i (lane_ready)
  );

  // one pump per lane, each working on its own burst
  for (genvar g = 0; g < LANES; g++) begin : gen_pump
    burst_pump burst_pump_inst (
      .aclk         (aclk),
      .reset        (reset),
      .req_valid_i  (lane_valid[g]),
      .req_i        (lane_req[g]),
      .req_ready_o  (lane_ready[g]),
      .beat_valid_o (pump_valid[g]),
      .beat_o       (pump_beat[g]),
      .beat_ready_i (pump_ready[g])
    );
  end

  beat_arbiter beat_arbiter_inst (
    .aclk         (aclk),
    .reset        (reset),
    .pump_valid_i (pump_valid),
    .pump_beat_i  (pump_beat),
    .pump_ready_o (pump_ready),
    .beat_valid_o (beat_valid_o),
    .beat_o       (beat_o),
    .beat_ready_i (beat_ready_i)
  );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic aclk_o,
  output logic reset_o
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 16;

  // free running clock, 100 ns period
  initial begin
    aclk_o = 1'b0;
    forever begin
      #HALF_PERIOD aclk_o = ~aclk_o;
    end
  end

  // synchronous reset held for a fixed number of edges
  // released just after the last one
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge aclk_o);
    #1 reset_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- sim/tb_burst_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "burst_config.svh"

module tb_burst_addr_gen;

  import burst_pkg::*;

  localparam int ADDR_W      = `BURST_ADDR_W;
  localparam int STRB_W      = `BURST_STRB_W;
  localparam int ID_NUM      = 1 << `BURST_ID_W;
  localparam int MAX_SIZE    = $clog2(STRB_W);
  localparam int RAND_BURSTS = 200;
  localparam int TIMEOUT     = 500;
  localparam int DRIVE_DLY   = 1;

  logic       aclk;
  logic       reset;
  logic       req_valid;
  burst_req_t req;
  logic       req_ready;
  logic       beat_valid;
  beat_t      beat;
  logic       beat_ready;

  // reference model, expected beats queued per id
  beat_t exp_q[ID_NUM][$];
  int    outstanding;
  int    beats_seen;
  int    bursts_sent;
  int    err_count;
  bit    drv_done;
  int    seed_ret;
  int    cycles;

  tb_clock_gen tb_clock_gen_inst (
    .aclk_o  (aclk),
    .reset_o (reset)
  );

  burst_addr_gen burst_addr_gen_inst (
    .aclk         (aclk),
    .reset        (reset),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_ready_o  (req_ready),
    .beat_valid_o (beat_valid),
    .beat_o       (beat),
    .beat_ready_i (beat_ready)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on failure");
  endtask

  task automatic check_beat(input string name, input beat_t got, input beat_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR t=%0t %s got=%b exp=%b", $time, name, got, exp));
    end
  endtask

  // lanes from the address up to the end of its size-aligned chunk
  function automatic logic [STRB_W-1:0] strobe_for(input logic [ADDR_W-1:0] a,
                                                   input logic [ADDR_W-1:0] nbytes);
    logic [STRB_W-1:0] s;
    int lo;
    int hi;
    lo = int'(a % STRB_W);
    hi = int'(((a & ~(nbytes - 1)) + nbytes - 1) % STRB_W);
    s  = '0;
    for (int j = 0; j < STRB_W; j++) begin
      if (j >= lo && j <= hi) begin
        s[j] = 1'b1;
      end
    end
    return s;
  endfunction

  // expand a descriptor into its beats, straight from the AXI rules
  task automatic expect_burst(input burst_req_t r);
    logic [ADDR_W-1:0] nbytes;
    logic [ADDR_W-1:0] start_al;
    logic [ADDR_W-1:0] region;
    logic [ADDR_W-1:0] lower;
    logic [ADDR_W-1:0] a;
    beat_t             b;
    nbytes   = ADDR_W'(1) << r.size;
    start_al = r.addr & ~(nbytes - 1);
    region   = nbytes * (ADDR_W'(r.len) + 1);
    lower    = r.addr - (r.addr % region);
    for (int i = 0; i <= int'(r.len); i++) begin
      case (r.burst)
        FIXED:   a = r.addr;
        INCR:    a = (i == 0) ? r.addr : start_al + ADDR_W'(i) * nbytes;
        default: a = lower + ((r.addr - lower + ADDR_W'(i) * nbytes) % region);
      endcase
      b.id    = r.id;
      b.addr  = a;
      b.strb  = strobe_for(a, nbytes);
      b.first = (i == 0);
      b.last  = (i == int'(r.len));
      exp_q[r.id].push_back(b);
      outstanding++;
    end
  endtask

  function automatic burst_req_t make_req(input burst_e bt, input int size, input int len,
                                          input bit unaligned);
    burst_req_t        r;
    logic [ADDR_W-1:0] a;
    a = $urandom;
    a = a & ~((ADDR_W'(1) << size) - 1);
    // nonzero offset inside the first chunk
    if (unaligned && size > 0) begin
      a = a | ADDR_W'(1 + ($urandom % ((1 << size) - 1)));
    end
    r.id    = '0;
    r.addr  = a;
    r.burst = bt;
    r.len   = 8'(len);
    r.size  = 3'(size);
    return r;
  endfunction

  function automatic burst_req_t random_req();
    int kind;
    int size;
    kind = $urandom % 3;
    size = $urandom % (MAX_SIZE + 1);
    case (kind)
      0:       return make_req(FIXED, size, $urandom % 32, $urandom % 2);
      1:       return make_req(INCR, size, $urandom % 32, $urandom % 2);
      // wrap lengths 2, 4, 8 or 16, start aligned to size
      default: return make_req(WRAP, size, (2 << ($urandom % 4)) - 1, 1'b0);
    endcase
  endfunction

  // give the burst an id not in flight, then hold valid until taken
  task automatic issue(input burst_req_t r);
    int  start;
    int  waited;
    bit  got;
    got    = 1'b0;
    waited = 0;
    while (!got) begin
      start = $urandom % ID_NUM;
      for (int k = 0; k < ID_NUM; k++) begin
        if (!got && exp_q[(start + k) % ID_NUM].size() == 0) begin
          r.id = `BURST_ID_W'((start + k) % ID_NUM);
          got  = 1'b1;
        end
      end
      if (!got) begin
        waited++;
        if (waited > TIMEOUT) fail_run("no free id came back within the timeout");
        @(posedge aclk);
        #DRIVE_DLY;
      end
    end
    req_valid = 1'b1;
    req       = r;
    waited    = 0;
    got       = 1'b0;
    while (!got) begin
      @(negedge aclk);
      // ready seen here means the transfer happens on the coming edge
      if (req_ready) begin
        expect_burst(r);
        bursts_sent++;
        got = 1'b1;
      end else begin
        waited++;
        if (waited > TIMEOUT) fail_run("descriptor was never accepted by req_ready_o");
      end
      @(posedge aclk);
      #DRIVE_DLY;
    end
    req_valid = 1'b0;
    // short random gap between descriptors
    repeat ($urandom % 3) begin
      @(posedge aclk);
      #DRIVE_DLY;
    end
  endtask

  task automatic drive_bursts();
    @(posedge aclk);
    #DRIVE_DLY;
    // incr over all sizes, aligned then unaligned start
    for (int s = 0; s <= MAX_SIZE; s++) begin
      for (int u = 0; u < 2; u++) begin
        issue(make_req(INCR, s, $urandom % 16, u != 0));
      end
    end
    // fixed with unaligned start
    for (int s = 0; s <= MAX_SIZE; s++) begin
      issue(make_req(FIXED, s, $urandom % 16, 1'b1));
    end
    // every wrap length at every size
    for (int w = 0; w < 4; w++) begin
      for (int s = 0; s <= MAX_SIZE; s++) begin
        issue(make_req(WRAP, s, (2 << w) - 1, 1'b0));
      end
    end
    for (int n = 0; n < RAND_BURSTS; n++) begin
      issue(random_req());
    end
    drv_done = 1'b1;
  endtask

  // random back-pressure, every taken beat checked against its id queue
  task automatic monitor_beats();
    int    idle;
    beat_t exp;
    idle = 0;
    while (!(drv_done && outstanding == 0)) begin
      @(posedge aclk);
      #DRIVE_DLY;
      beat_ready = ($urandom % 4) != 0;
      @(negedge aclk);
      if (beat_valid && beat_ready) begin
        if (exp_q[beat.id].size() == 0) begin
          fail_run($sformatf("beat for id %0d arrived with no burst outstanding", beat.id));
        end
        exp = exp_q[beat.id].pop_front();
        outstanding--;
        beats_seen++;
        check_bit("beat_o.first", beat.first, exp.first);
        check_bit("beat_o.last", beat.last, exp.last);
        check_beat("beat_o", beat, exp);
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) fail_run("no beat was taken within the timeout");
      end
    end
  endtask

  initial begin
    req_valid   = 1'b0;
    req         = '0;
    beat_ready  = 1'b0;
    outstanding = 0;
    beats_seen  = 0;
    bursts_sent = 0;
    err_count   = 0;
    drv_done    = 1'b0;
    seed_ret    = $urandom(32'h9b16_8fd9);
    // output must stay quiet while reset is held
    @(posedge aclk);
    cycles = 0;
    while (reset) begin
      @(negedge aclk);
      if (reset) check_bit("beat_valid_o", beat_valid, 1'b0);
      cycles++;
      if (cycles > TIMEOUT) fail_run("reset was never released");
    end
    check_bit("req_ready_o", req_ready, 1'b1);
    fork
      drive_bursts();
      monitor_beats();
    join
    // drain with ready high, nothing extra may show up
    @(posedge aclk);
    #DRIVE_DLY;
    beat_ready = 1'b1;
    repeat (20) begin
      @(negedge aclk);
      check_bit("beat_valid_o", beat_valid, 1'b0);
    end
    check_bit("req_ready_o", req_ready, 1'b1);
    for (int i = 0; i < ID_NUM; i++) begin
      if (exp_q[i].size() != 0) begin
        $display("model queue for id %0d still holds %0d beats", i, exp_q[i].size());
        err_count++;
      end
    end
    $display("bursts sent %0d, beats checked %0d", bursts_sent, beats_seen);
    if (err_count == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      fail_run("expected beats were left over at the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
src/burst_pkg.sv
src/burst_dispatch.sv
src/burst_pump.sv
src/beat_arbiter.sv
src/burst_addr_gen.sv
sim/tb_clock_gen.sv
sim/tb_burst_addr_gen.sv
